//--- src.f
tone_pkg.sv
tone_ctrl.sv
burst_timer.sv
phase_accum.sv
sin_cos_lut.sv
iq_gain.sv
iq_tone_gen.sv
iq_tone_gen_assertions.sv
tb_iq_tone_gen.sv

//--- Bender.yml
package:
  name: iq_tone_gen

sources:
  - files:
      - tone_pkg.sv
      - tone_ctrl.sv
      - burst_timer.sv
      - phase_accum.sv
      - sin_cos_lut.sv
      - iq_gain.sv
      - iq_tone_gen.sv
  - target: test
    files:
      - iq_tone_gen_assertions.sv
      - tb_iq_tone_gen.sv

//--- tb_iq_tone_gen.sv
`timescale 1ns/1ps

module tb_iq_tone_gen import tone_pkg::*;;

  localparam int LUT_SIZE = 64;
  localparam int DATA_W   = 12;
  localparam int ACC_W    = 24;
  localparam int LEN_W    = 16;
  localparam int IDX_W    = $clog2(4*LUT_SIZE);

  logic                     clk;
  logic                     rstn;
  logic                     start;
  logic [ACC_W-1:0]         freq_word;
  logic [GAIN_W-1:0]        gain;
  logic [LEN_W-1:0]         burst_len;
  logic                     busy;
  logic signed [DATA_W-1:0] i_data;
  logic signed [DATA_W-1:0] q_data;
  logic                     iq_valid;
  logic                     done;

  integer seed;
  int     err_count;
  int     valid_count;
  int     done_count;
  int     total_fails;

  iq_tone_gen #(
    .LUT_SIZE(LUT_SIZE), .DATA_W(DATA_W), .ACC_W(ACC_W), .LEN_W(LEN_W)
  ) iq_tone_gen_i (
    .clk, .rstn, .start, .freq_word, .gain, .burst_len,
    .busy, .i_data, .q_data, .iq_valid, .done
  );

  bind iq_tone_gen iq_tone_gen_assertions #(
    .LUT_SIZE(LUT_SIZE), .DATA_W(DATA_W), .ACC_W(ACC_W), .LEN_W(LEN_W)
  ) assertions_i (
    .clk(clk), .rstn(rstn), .start(start), .freq_word(freq_word), .gain(gain),
    .burst_len(burst_len), .busy(busy), .i_data(i_data), .q_data(q_data),
    .iq_valid(iq_valid), .done(done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Outputs are counted half a cycle after they change
  always @(negedge clk) begin
    if (iq_valid) valid_count++;
    if (done) done_count++;
  end

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic pulse_start(input logic [ACC_W-1:0] word, input logic [GAIN_W-1:0] g,
                             input logic [LEN_W-1:0] len);
    freq_word = word;
    gain      = g;
    burst_len = len;
    start     = 1'b1;
    next_cycle();
    start     = 1'b0;
  endtask

  task automatic launch_burst(input logic [ACC_W-1:0] word, input logic [GAIN_W-1:0] g,
                              input logic [LEN_W-1:0] len);
    valid_count = 0;
    done_count  = 0;
    pulse_start(word, g, len);
  endtask

  task automatic finish_burst(input string name, input int exp_len);
    int waited;
    waited = 0;
    while (done_count == 0 && waited < exp_len + 20) begin
      next_cycle();
      waited++;
    end
    if (done_count == 0) begin
      $display("Timed out in %s while waiting for done", name);
      err_count++;
    end else if (valid_count != exp_len) begin
      $display("[ERROR] %s: expected %0d valid samples, actual %0d", name, exp_len, valid_count);
      err_count++;
    end
    waited = 0;
    while (busy && waited < 10) begin
      next_cycle();
      waited++;
    end
    if (busy) begin
      $display("Timed out in %s while waiting for busy to fall", name);
      err_count++;
    end
  endtask

  task automatic run_burst(input string name, input logic [ACC_W-1:0] word,
                           input logic [GAIN_W-1:0] g, input int len);
    launch_burst(word, g, LEN_W'(len));
    finish_burst(name, len);
  endtask

  // Nothing may start while the generator is meant to stay idle
  task automatic check_quiet(input string name, input int cycles);
    for (int c = 0; c < cycles; c++) begin
      if (busy || iq_valid) begin
        $display("[ERROR] %s: expected busy 0 and iq_valid 0, actual busy %0b and iq_valid %0b",
                 name, busy, iq_valid);
        err_count++;
      end
      next_cycle();
    end
  endtask

  initial begin
    logic [ACC_W-1:0] sweep_word;
    logic [ACC_W-1:0] word;
    logic [GAIN_W-1:0] g;
    int len;
    seed        = 32'hc153_8821;
    err_count   = 0;
    valid_count = 0;
    done_count  = 0;
    start       = 1'b0;
    freq_word   = '0;
    gain        = '0;
    burst_len   = '0;
    rstn        = 1'b0;
    repeat (4) @(posedge clk);
    #10;
    rstn = 1'b1;

    check_quiet("after_reset", 5);

    // One index step per sample visits every entry of every quadrant
    sweep_word = ACC_W'(1) << (ACC_W - IDX_W);
    run_burst("gain_unity", sweep_word, 8'd128, 4 * LUT_SIZE);
    run_burst("gain_zero", sweep_word, 8'd0, 4 * LUT_SIZE);
    run_burst("gain_max", sweep_word, 8'd255, 4 * LUT_SIZE);

    for (int n = 0; n < 8; n++) begin
      word = ACC_W'($random(seed));
      g    = GAIN_W'($random(seed));
      len  = ($random(seed) & 31) + 1;
      run_burst($sformatf("random_%0d", n), word, g, len);
    end

    launch_burst(24'h123457, 8'd200, 16'd20);
    repeat (5) next_cycle();
    pulse_start(24'h0f0f0f, 8'd60, 16'd7);
    finish_burst("start_while_busy", 20);

    launch_burst(24'h2a0001, 8'd128, 16'd3);
    repeat (3) next_cycle();
    pulse_start(24'h00ffff, 8'd90, 16'd9);  // Lands in the drain state
    finish_burst("start_in_drain", 3);

    pulse_start(24'h345678, 8'd100, 16'd0);
    check_quiet("zero_length_start", 10);

    total_fails = err_count + iq_tone_gen_i.assertions_i.fail_count;
    $display("Run finished with %0d testbench errors and %0d assertion failures",
             err_count, iq_tone_gen_i.assertions_i.fail_count);
    if (total_fails == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- iq_tone_gen_assertions.sv
`timescale 1ns/1ps

module iq_tone_gen_assertions import tone_pkg::*; #(
  parameter int LUT_SIZE = 64,
  parameter int DATA_W   = 12,
  parameter int ACC_W    = 24,
  parameter int LEN_W    = 16
) (
  input logic                     clk,
  input logic                     rstn,
  input logic                     start,
  input logic [ACC_W-1:0]         freq_word,
  input logic [GAIN_W-1:0]        gain,
  input logic [LEN_W-1:0]         burst_len,
  input logic                     busy,
  input logic signed [DATA_W-1:0] i_data,
  input logic signed [DATA_W-1:0] q_data,
  input logic                     iq_valid,
  input logic                     done
);

  localparam int IDX_W = $clog2(4*LUT_SIZE);
  localparam int MAX_V = (1 << (DATA_W - 1)) - 1;
  localparam int MIN_V = -MAX_V - 1;

  int fail_count = 0;

  logic [LEN_W-1:0]  run_left;  // Run cycles still expected
  logic              run_m;
  logic              en_d1;
  logic              en_d2;
  logic              en_d3;
  logic              busy_m;
  logic              accept_m;
  logic              seen_burst;
  logic [ACC_W-1:0]  word_m;
  logic [ACC_W-1:0]  phase_m;  // Phase of the sample due at the output
  logic [GAIN_W-1:0] gain_m;
  int                sin_idx;
  int                cos_idx;
  int                exp_i;
  int                exp_q;

  // Signed table value for a full-turn index, folded by quadrant
  function automatic int table_value(input int idx);
    int quad;
    int off;
    int entry;
    int mag;
    quad  = idx / LUT_SIZE;
    off   = idx % LUT_SIZE;
    entry = (quad % 2 == 1) ? LUT_SIZE - 1 - off : off;  // Second and fourth quadrants mirror
    mag   = quarter_sine(entry, LUT_SIZE, DATA_W);
    return (quad >= 2) ? -mag : mag;
  endfunction

  function automatic int apply_gain(input int v, input int g);
    int p;
    p = (v * g) >>> GAIN_FRAC;  // Rounds toward minus infinity
    if (p > MAX_V) begin
      return MAX_V;
    end else if (p < MIN_V) begin
      return MIN_V;
    end
    return p;
  endfunction

  assign run_m    = (run_left != '0);
  assign busy_m   = run_m || en_d1 || en_d2;
  assign accept_m = start && !busy_m && (burst_len != '0);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      run_left   <= '0;
      en_d1      <= 1'b0;
      en_d2      <= 1'b0;
      en_d3      <= 1'b0;
      seen_burst <= 1'b0;
      word_m     <= '0;
      phase_m    <= '0;
      gain_m     <= '0;
    end else begin
      en_d1 <= run_m;
      en_d2 <= en_d1;
      en_d3 <= en_d2;
      if (en_d2) begin
        seen_burst <= 1'b1;
      end
      if (accept_m) begin
        run_left <= burst_len;
        word_m   <= freq_word;
        gain_m   <= gain;
        phase_m  <= '0;
      end else begin
        if (run_m) begin
          run_left <= run_left - 1'b1;
        end
        if (en_d2) begin
          phase_m <= phase_m + word_m;
        end
      end
    end
  end

  always_comb begin
    sin_idx = int'(phase_m[ACC_W-1 -: IDX_W]);
    cos_idx = (sin_idx + LUT_SIZE) % (4 * LUT_SIZE);
    exp_q   = apply_gain(table_value(sin_idx), int'(gain_m));
    exp_i   = apply_gain(table_value(cos_idx), int'(gain_m));
  end

  a_valid_window: assert property (@(posedge clk) disable iff (!rstn) iq_valid == en_d2)
    else begin
      fail_count = fail_count + 1;
      $error("[ERROR] a_valid_window: expected iq_valid %0b, actual %0b",
             $sampled(en_d2), $sampled(iq_valid));
    end

  a_busy_level: assert property (@(posedge clk) disable iff (!rstn) busy == busy_m)
    else begin
      fail_count = fail_count + 1;
      $error("[ERROR] a_busy_level: expected busy %0b, actual %0b",
             $sampled(busy_m), $sampled(busy));
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (!rstn) done == (en_d3 && !en_d2))
    else begin
      fail_count = fail_count + 1;
      $error("[ERROR] a_done_pulse: expected done %0b, actual %0b",
             $sampled(en_d3 && !en_d2), $sampled(done));
    end

  a_i_value: assert property (@(posedge clk) disable iff (!rstn) en_d2 |-> int'(i_data) == exp_i)
    else begin
      fail_count = fail_count + 1;
      $error("[ERROR] a_i_value: expected i_data %0d, actual %0d",
             $sampled(exp_i), $sampled(i_data));
    end

  a_q_value: assert property (@(posedge clk) disable iff (!rstn) en_d2 |-> int'(q_data) == exp_q)
    else begin
      fail_count = fail_count + 1;
      $error("[ERROR] a_q_value: expected q_data %0d, actual %0d",
             $sampled(exp_q), $sampled(q_data));
    end

  // Before the first sample the outputs still hold their reset value
  a_idle_zero: assert property (@(posedge clk) disable iff (!rstn)
    (!seen_burst && !en_d2) |-> (i_data == '0 && q_data == '0))
    else begin
      fail_count = fail_count + 1;
      $error("[ERROR] a_idle_zero: expected i_data 0 and q_data 0, actual %0d and %0d",
             $sampled(i_data), $sampled(q_data));
    end

endmodule

//--- iq_tone_gen.sv
`timescale 1ns/1ps

module iq_tone_gen import tone_pkg::*; #(
  parameter int LUT_SIZE = 64,
  parameter int DATA_W   = 12,
  parameter int ACC_W    = 24,
  parameter int LEN_W    = 16
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     start,
  input  logic [ACC_W-1:0]         freq_word,
  input  logic [GAIN_W-1:0]        gain,
  input  logic [LEN_W-1:0]         burst_len,
  output logic                     busy,
  output logic signed [DATA_W-1:0] i_data,
  output logic signed [DATA_W-1:0] q_data,
  output logic                     iq_valid,
  output logic                     done
);

  localparam int IDX_W = $clog2(4*LUT_SIZE);

  logic                     load;
  logic                     phase_en;
  logic                     last;
  logic [IDX_W-1:0]         phase_idx;
  logic signed [DATA_W-1:0] sin_val;
  logic signed [DATA_W-1:0] cos_val;
  logic                     lut_valid;

  tone_ctrl #(.LEN_W(LEN_W)) tone_ctrl_i (
    .clk, .rstn, .start, .burst_len, .last,
    .load, .phase_en, .busy, .done
  );

  burst_timer #(.LEN_W(LEN_W)) burst_timer_i (
    .clk, .rstn, .load, .burst_len, .phase_en, .last
  );

  phase_accum #(.ACC_W(ACC_W), .LUT_SIZE(LUT_SIZE)) phase_accum_i (
    .clk, .rstn, .load, .freq_word, .phase_en, .phase_idx
  );

  // One register stage here and one in the gain stage make up PIPE_DEPTH
  sin_cos_lut #(.LUT_SIZE(LUT_SIZE), .DATA_W(DATA_W)) sin_cos_lut_i (
    .clk, .rstn, .phase_idx, .phase_en, .sin_val, .cos_val, .lut_valid
  );

  iq_gain #(.DATA_W(DATA_W)) iq_gain_i (
    .clk, .rstn, .load, .gain, .sin_val, .cos_val, .lut_valid,
    .i_data, .q_data, .iq_valid
  );

endmodule

//--- iq_gain.sv
`timescale 1ns/1ps

module iq_gain import tone_pkg::*; #(
  parameter int DATA_W = 12
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     load,
  input  logic [GAIN_W-1:0]        gain,
  input  logic signed [DATA_W-1:0] sin_val,
  input  logic signed [DATA_W-1:0] cos_val,
  input  logic                     lut_valid,
  output logic signed [DATA_W-1:0] i_data,
  output logic signed [DATA_W-1:0] q_data,
  output logic                     iq_valid
);

  localparam int PROD_W = DATA_W + GAIN_W + 1;
  localparam logic signed [PROD_W-1:0] MAX_V = PROD_W'((1 << (DATA_W - 1)) - 1);
  localparam logic signed [PROD_W-1:0] MIN_V = -MAX_V - 1;

  logic [GAIN_W-1:0]        gain_q;
  logic signed [GAIN_W:0]   gain_s;
  logic signed [PROD_W-1:0] i_prod;
  logic signed [PROD_W-1:0] q_prod;

  function automatic logic signed [DATA_W-1:0] saturate(input logic signed [PROD_W-1:0] v);
    if (v > MAX_V) begin
      return MAX_V[DATA_W-1:0];
    end else if (v < MIN_V) begin
      return MIN_V[DATA_W-1:0];
    end
    return v[DATA_W-1:0];
  endfunction

  always_ff @(posedge clk) begin
    if (load) begin
      gain_q <= gain;
    end
  end

  assign gain_s = signed'({1'b0, gain_q});  // Gain is unsigned, so zero-extend
  assign i_prod = (cos_val * gain_s) >>> GAIN_FRAC;
  assign q_prod = (sin_val * gain_s) >>> GAIN_FRAC;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      i_data   <= '0;
      q_data   <= '0;
      iq_valid <= 1'b0;
    end else begin
      iq_valid <= lut_valid;
      if (lut_valid) begin
        i_data <= saturate(i_prod);
        q_data <= saturate(q_prod);
      end
    end
  end

endmodule

//--- sin_cos_lut.sv
`timescale 1ns/1ps

module sin_cos_lut import tone_pkg::*; #(
  parameter int LUT_SIZE = 64,
  parameter int DATA_W   = 12
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic [$clog2(4*LUT_SIZE)-1:0] phase_idx,
  input  logic                          phase_en,
  output logic signed [DATA_W-1:0]      sin_val,
  output logic signed [DATA_W-1:0]      cos_val,
  output logic                          lut_valid
);

  localparam int IDX_W = $clog2(4*LUT_SIZE);
  localparam int OFF_W = $clog2(LUT_SIZE);

  typedef logic signed [DATA_W-1:0] table_t [LUT_SIZE];

  function automatic table_t make_table();
    table_t t;
    for (int k = 0; k < LUT_SIZE; k++) begin
      t[k] = DATA_W'(quarter_sine(k, LUT_SIZE, DATA_W));
    end
    return t;
  endfunction

  localparam table_t QUARTER = make_table();

  // Splits a full-turn index into quadrant and offset, and reads the
  // quarter table mirrored and negated as the quadrant requires
  function automatic logic signed [DATA_W-1:0] fold(input logic [IDX_W-1:0] idx);
    logic [1:0]               quad;
    logic [OFF_W-1:0]         off;
    logic [OFF_W-1:0]         entry;
    logic signed [DATA_W-1:0] mag;
    quad  = idx[IDX_W-1 -: 2];
    off   = idx[OFF_W-1:0];
    entry = quad[0] ? ~off : off;  // Same as LUT_SIZE-1 minus the offset
    mag   = QUARTER[entry];
    // Entries stay within plus and minus full scale, so negation is exact
    return quad[1] ? -mag : mag;
  endfunction

  logic [IDX_W-1:0]         cos_idx;
  logic signed [DATA_W-1:0] sin_next;
  logic signed [DATA_W-1:0] cos_next;

  assign cos_idx  = phase_idx + IDX_W'(LUT_SIZE);  // Cosine leads sine by a quarter turn
  assign sin_next = fold(phase_idx);
  assign cos_next = fold(cos_idx);

  always_ff @(posedge clk) begin
    if (phase_en) begin
      sin_val <= sin_next;
      cos_val <= cos_next;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lut_valid <= 1'b0;
    end else begin
      lut_valid <= phase_en;
    end
  end

endmodule

//--- phase_accum.sv
`timescale 1ns/1ps

module phase_accum #(
  parameter int ACC_W    = 24,
  parameter int LUT_SIZE = 64
) (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           load,
  input  logic [ACC_W-1:0]               freq_word,
  input  logic                           phase_en,
  output logic [$clog2(4*LUT_SIZE)-1:0]  phase_idx
);

  localparam int IDX_W = $clog2(4*LUT_SIZE);

  logic [ACC_W-1:0] acc;
  logic [ACC_W-1:0] word_q;  // Tuning word held for the whole burst

  always_ff @(posedge clk) begin
    if (load) begin
      word_q <= freq_word;
    end
  end

  // Each burst starts at phase zero, and the sum wraps modulo 2^ACC_W
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      acc <= '0;
    end else if (load) begin
      acc <= '0;
    end else if (phase_en) begin
      acc <= acc + word_q;
    end
  end

  assign phase_idx = acc[ACC_W-1 -: IDX_W];  // Top bits address a full turn

endmodule

//--- burst_timer.sv
`timescale 1ns/1ps

module burst_timer #(
  parameter int LEN_W = 16
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             load,
  input  logic [LEN_W-1:0] burst_len,
  input  logic             phase_en,
  output logic             last
);

  logic [LEN_W-1:0] remain;  // Samples still to be issued, this one included

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      remain <= '0;
    end else if (load) begin
      remain <= burst_len;
    end else if (phase_en) begin
      remain <= remain - 1'b1;
    end
  end

  // High only in the final run cycle
  assign last = phase_en && (remain == LEN_W'(1));

endmodule

//--- tone_ctrl.sv
`timescale 1ns/1ps

module tone_ctrl import tone_pkg::*; #(
  parameter int LEN_W = 16
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             start,
  input  logic [LEN_W-1:0] burst_len,
  input  logic             last,
  output logic             load,
  output logic             phase_en,
  output logic             busy,
  output logic             done
);

  localparam int DRAIN_W = (PIPE_DEPTH > 1) ? $clog2(PIPE_DEPTH) : 1;

  tone_state_e        state;
  logic [DRAIN_W-1:0] drain_cnt;
  logic               accept;

  // A burst of zero samples would never raise last, so it is refused here
  assign accept   = start && (state == ST_IDLE) && (burst_len != '0);
  assign load     = accept;
  assign phase_en = (state == ST_RUN);
  assign busy     = (state != ST_IDLE);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= ST_IDLE;
      drain_cnt <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (last) begin
            state     <= ST_DRAIN;
            drain_cnt <= '0;
          end
        end
        ST_DRAIN: begin
          // Wait for the last sample to leave the table and gain registers
          if (drain_cnt == DRAIN_W'(PIPE_DEPTH - 1)) begin
            state <= ST_IDLE;
            done  <= 1'b1;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

//--- tone_pkg.sv
package tone_pkg;

  // Controller states of the burst generator
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_RUN   = 2'd1,
    ST_DRAIN = 2'd2
  } tone_state_e;

  localparam int GAIN_W    = 8;  // Unsigned gain input width
  localparam int GAIN_FRAC = 7;  // Gain of 128 is unity

  // Registered stages between phase_idx and the IQ outputs
  localparam int PIPE_DEPTH = 2;

  localparam real PI = 3.14159265358979323846;

  // Entry k of a quarter-wave sine table sampled at half-step offsets,
  // so entry k sits at angle (k + 0.5) / size of a quarter turn
  function automatic int quarter_sine(input int k, input int size, input int width);
    real full_scale;
    real angle;
    real value;
    full_scale = real'((1 << (width - 1)) - 1);
    angle      = (real'(k) + 0.5) / real'(size) * (PI / 2.0);
    value      = full_scale * $sin(angle);
    return $rtoi(value + 0.5);  // Values are never negative, so this rounds to nearest
  endfunction

endpackage
